// ==== dv/rx_mac_fifo_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_mac_fifo_asserts (
   input logic       rx_mac_aclk,
   input logic       rx_mac_resetn,
   input logic [7:0] rx_axis_fifo_tdata,
   input logic       rx_axis_fifo_tvalid,
   input logic       rx_axis_fifo_tlast,
   input logic       rx_axis_fifo_tready,
   input logic       pause_req,
   input logic       rx_fifo_overflow
);

   // failure tallies, read back by the testbench
   int unsigned hold_fails  = 0;
   int unsigned pause_fails = 0;
   int unsigned ovf_fails   = 0;

   // ----------------------------------------------------------------------
   // client stream stays put under back-pressure
   // ----------------------------------------------------------------------
   property stream_holds;
      @(posedge rx_mac_aclk) disable iff (!rx_mac_resetn)
         (rx_axis_fifo_tvalid && !rx_axis_fifo_tready) |=>
            (rx_axis_fifo_tvalid && $stable(rx_axis_fifo_tdata) &&
             $stable(rx_axis_fifo_tlast));
   endproperty

   a_stream_holds: assert property (stream_holds) else begin
      $error("client stream changed while tready was low");
      hold_fails++;
   end

   // ----------------------------------------------------------------------
   // single cycle pulses
   // ----------------------------------------------------------------------
   a_pause_pulse: assert property (
      @(posedge rx_mac_aclk) disable iff (!rx_mac_resetn) pause_req |=> !pause_req
   ) else begin
      $error("pause_req stayed high for more than one cycle");
      pause_fails++;
   end

   a_ovf_pulse: assert property (
      @(posedge rx_mac_aclk) disable iff (!rx_mac_resetn)
         rx_fifo_overflow |=> !rx_fifo_overflow
   ) else begin
      $error("rx_fifo_overflow stayed high for more than one cycle");
      ovf_fails++;
   end

endmodule

bind rx_mac_fifo_top rx_mac_fifo_asserts u_asserts (
   .rx_mac_aclk         (rx_mac_aclk),
   .rx_mac_resetn       (rx_mac_resetn),
   .rx_axis_fifo_tdata  (rx_axis_fifo_tdata),
   .rx_axis_fifo_tvalid (rx_axis_fifo_tvalid),
   .rx_axis_fifo_tlast  (rx_axis_fifo_tlast),
   .rx_axis_fifo_tready (rx_axis_fifo_tready),
   .pause_req           (pause_req),
   .rx_fifo_overflow    (rx_fifo_overflow)
);

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic rx_mac_aclk,
   output logic rx_mac_resetn
);

   // 100 ns period
   initial begin
      rx_mac_aclk = 1'b0;
      forever begin
         #50 rx_mac_aclk = ~rx_mac_aclk;
      end
   end

   // reset low for the first two rising edges
   initial begin
      rx_mac_resetn = 1'b0;
      repeat (2) @(posedge rx_mac_aclk);
      rx_mac_resetn <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== dv/tb_rx_mac_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rx_mac_fifo import rx_mac_pkg::*; ();

   localparam int DEPTH       = 256;
   localparam int GOOD_FRAMES = 12;
   localparam int MIX_FRAMES  = 12;
   localparam int BP_FRAMES   = 10;
   localparam int OVF_FRAMES  = 8;
   localparam int MAX_LEN     = 80;
   localparam int BIG_LEN     = 300;
   // four cycles per byte sent, margin covers gaps and drain waits
   localparam int WATCHDOG_CYCLES =
      ((GOOD_FRAMES + MIX_FRAMES + BP_FRAMES + OVF_FRAMES) * MAX_LEN + BIG_LEN) * 4 + 3000;

   typedef enum {READY_LOW, READY_HIGH, READY_RANDOM} ready_mode_t;

   logic        rx_mac_aclk;
   logic        rx_mac_resetn;
   byte_t       rx_axis_mac_tdata;
   logic        rx_axis_mac_tvalid;
   logic        rx_axis_mac_tlast;
   logic        rx_axis_mac_tuser;
   byte_t       rx_axis_fifo_tdata;
   logic        rx_axis_fifo_tvalid;
   logic        rx_axis_fifo_tlast;
   logic        rx_axis_fifo_tready;
   logic        pause_req;
   logic [15:0] pause_val;
   logic [31:0] rx_error_count;
   logic        rx_fifo_overflow;

   // sent frames, with bad and too-large flags
   byte_t       sent_data[$];
   int          sent_start[$];
   int          sent_len[$];
   bit          sent_bad[$];
   bit          sent_big[$];
   int          modeled = 0;
   // frames the client should see, in order
   int          exp_start[$];
   int          exp_len[$];
   // client frame being collected
   byte_t       rx_cur[$];

   ready_mode_t ready_mode  = READY_LOW;
   bit          lossy       = 1'b0;
   logic [31:0] data_rng    = 32'h92df6d24;
   logic [31:0] ready_rng   = 32'h92df6d24;
   logic [15:0] pause_next  = PAUSE_QUANTA_MAX;
   int          err_cnt     = 0;
   int          missing_cnt = 0;
   int          ovf_cnt     = 0;
   int          pause_cnt   = 0;
   int          tests_run   = 0;
   int          tests_bad   = 0;
   int          err_base    = 0;

   tb_clk_gen u_clk_gen (
      .rx_mac_aclk   (rx_mac_aclk),
      .rx_mac_resetn (rx_mac_resetn)
   );

   rx_mac_fifo_top #(
      .FIFO_DEPTH (DEPTH)
   ) DUT (
      .rx_mac_aclk         (rx_mac_aclk),
      .rx_mac_resetn       (rx_mac_resetn),
      .rx_axis_mac_tdata   (rx_axis_mac_tdata),
      .rx_axis_mac_tvalid  (rx_axis_mac_tvalid),
      .rx_axis_mac_tlast   (rx_axis_mac_tlast),
      .rx_axis_mac_tuser   (rx_axis_mac_tuser),
      .rx_axis_fifo_tdata  (rx_axis_fifo_tdata),
      .rx_axis_fifo_tvalid (rx_axis_fifo_tvalid),
      .rx_axis_fifo_tlast  (rx_axis_fifo_tlast),
      .rx_axis_fifo_tready (rx_axis_fifo_tready),
      .pause_req           (pause_req),
      .pause_val           (pause_val),
      .rx_error_count      (rx_error_count),
      .rx_fifo_overflow    (rx_fifo_overflow)
   );

   // ----------------------------------------------------------------------
   // random numbers and reference model
   // ----------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int rand_range(input int lo, input int hi);
      data_rng = xorshift32(data_rng);
      return lo + int'(data_rng % (hi - lo + 1));
   endfunction

   // clean frames that fit the buffer reach the client, in send order
   function automatic void update_expected();
      while (modeled < sent_len.size()) begin
         if (!sent_bad[modeled] && !sent_big[modeled]) begin
            exp_start.push_back(sent_start[modeled]);
            exp_len.push_back(sent_len[modeled]);
         end
         modeled++;
      end
   endfunction

   function automatic int total_errors();
      return err_cnt + int'(DUT.u_asserts.hold_fails + DUT.u_asserts.pause_fails +
                            DUT.u_asserts.ovf_fails);
   endfunction

   function automatic bit same_frame(input int start, input int len);
      if (rx_cur.size() != len) begin
         return 1'b0;
      end
      for (int i = 0; i < len; i++) begin
         if (rx_cur[i] != sent_data[start + i]) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   // ----------------------------------------------------------------------
   // checks
   // ----------------------------------------------------------------------
   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("Error at %0t: %s expected %0h, got %0h", $time, name, exp, got);
         err_cnt++;
      end
   endtask

   task automatic check_frame(input int start, input int len);
      assert (rx_cur.size() == len) else begin
         $display("Error at %0t: rx_axis_fifo_tlast expected after byte %0d, got after %0d",
                  $time, len, rx_cur.size());
         err_cnt++;
      end
      for (int i = 0; i < rx_cur.size() && i < len; i++) begin
         assert (rx_cur[i] == sent_data[start + i]) else begin
            $display("Error at %0t: rx_axis_fifo_tdata byte %0d expected %02h, got %02h",
                     $time, i, sent_data[start + i], rx_cur[i]);
            err_cnt++;
         end
      end
   endtask

   task automatic match_frame();
      if (lossy) begin
         // overflow loses frames whole, skip them
         while (exp_len.size() > 1 && !same_frame(exp_start[0], exp_len[0])) begin
            void'(exp_start.pop_front());
            void'(exp_len.pop_front());
            missing_cnt++;
         end
      end
      assert (exp_len.size() > 0) else begin
         $display("Error: client got a %0d byte frame at %0t that was not expected",
                  rx_cur.size(), $time);
         err_cnt++;
      end
      if (exp_len.size() > 0) begin
         check_frame(exp_start.pop_front(), exp_len.pop_front());
      end
   endtask

   task automatic check_all_delivered();
      assert (exp_len.size() == 0 && rx_cur.size() == 0) else begin
         $display("Error: %0d frames missing and %0d stray bytes at the client by %0t",
                  exp_len.size(), rx_cur.size(), $time);
         err_cnt++;
      end
      exp_start.delete();
      exp_len.delete();
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (total_errors() == err_base) begin
         $display("test %s: passed", name);
      end else begin
         $display("test %s: failed with %0d errors", name, total_errors() - err_base);
         tests_bad++;
      end
      err_base = total_errors();
   endtask

   // ----------------------------------------------------------------------
   // mac side stimulus
   // ----------------------------------------------------------------------
   task automatic drive_idle();
      @(posedge rx_mac_aclk);
      rx_axis_mac_tvalid <= 1'b0;
      rx_axis_mac_tlast  <= 1'b0;
      rx_axis_mac_tuser  <= 1'b0;
   endtask

   task automatic send_frame(input int len, input bit bad, input int gap);
      byte_t b;
      sent_start.push_back(sent_data.size());
      sent_len.push_back(len);
      sent_bad.push_back(bad);
      sent_big.push_back(len > DEPTH);
      for (int i = 0; i < len; i++) begin
         b = byte_t'(rand_range(0, 255));
         sent_data.push_back(b);
         @(posedge rx_mac_aclk);
         rx_axis_mac_tdata  <= b;
         rx_axis_mac_tvalid <= 1'b1;
         rx_axis_mac_tlast  <= (i == len - 1);
         rx_axis_mac_tuser  <= bad && (i == len - 1);
      end
      update_expected();
      repeat (gap) drive_idle();
   endtask

   // drained once tvalid stays low for a while
   task automatic wait_drain();
      int quiet;
      quiet = 0;
      while (quiet < 16) begin
         @(posedge rx_mac_aclk);
         quiet = rx_axis_fifo_tvalid ? 0 : quiet + 1;
      end
      @(negedge rx_mac_aclk);
   endtask

   // client ready
   initial begin
      rx_axis_fifo_tready = 1'b0;
      forever begin
         @(posedge rx_mac_aclk);
         ready_rng = xorshift32(ready_rng);
         case (ready_mode)
            READY_HIGH:   rx_axis_fifo_tready <= 1'b1;
            READY_RANDOM: rx_axis_fifo_tready <= ready_rng[0];
            default:      rx_axis_fifo_tready <= 1'b0;
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // compare process and pulse monitors
   // ----------------------------------------------------------------------
   always @(posedge rx_mac_aclk) begin
      if (rx_mac_resetn && rx_axis_fifo_tvalid && rx_axis_fifo_tready) begin
         rx_cur.push_back(rx_axis_fifo_tdata);
         if (rx_axis_fifo_tlast) begin
            match_frame();
            rx_cur.delete();
         end
      end
   end

   // pause values alternate, max first
   always @(posedge rx_mac_aclk) begin
      if (rx_mac_resetn && rx_fifo_overflow) begin
         ovf_cnt++;
      end
      if (rx_mac_resetn && pause_req) begin
         assert (pause_val == pause_next) else begin
            $display("Error at %0t: pause_val expected %04h, got %04h",
                     $time, pause_next, pause_val);
            err_cnt++;
         end
         pause_cnt++;
         pause_next = (pause_next == PAUSE_QUANTA_MAX) ? PAUSE_QUANTA_ZERO : PAUSE_QUANTA_MAX;
      end
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge rx_mac_aclk);
      $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Done: errors found");
      $finish;
   end

   // ----------------------------------------------------------------------
   // test sequence
   // ----------------------------------------------------------------------
   initial begin
      int bad_sent;
      int ovf_base;
      int pause_base;
      bit bad;
      rx_axis_mac_tdata  = '0;
      rx_axis_mac_tvalid = 1'b0;
      rx_axis_mac_tlast  = 1'b0;
      rx_axis_mac_tuser  = 1'b0;
      bad_sent           = 0;
      wait (rx_mac_resetn === 1'b1);
      @(negedge rx_mac_aclk);

      // 1 outputs after reset
      check_value("rx_axis_fifo_tvalid", rx_axis_fifo_tvalid, 0);
      check_value("pause_req", pause_req, 0);
      check_value("rx_fifo_overflow", rx_fifo_overflow, 0);
      check_value("rx_error_count", rx_error_count, 0);
      finish_test("after reset");

      // 2 good frames, client always ready
      ready_mode <= READY_HIGH;
      for (int i = 0; i < GOOD_FRAMES; i++) begin
         send_frame(rand_range(1, 64), 1'b0, rand_range(0, 3));
      end
      drive_idle();
      wait_drain();
      check_all_delivered();
      finish_test("good frames");

      // 3 bad frames mixed in, first one always bad
      for (int i = 0; i < MIX_FRAMES; i++) begin
         bad = (i == 0) || (rand_range(0, 2) == 0);
         bad_sent += int'(bad);
         send_frame(rand_range(1, 64), bad, rand_range(0, 3));
      end
      drive_idle();
      wait_drain();
      check_all_delivered();
      check_value("rx_error_count", rx_error_count, bad_sent);
      finish_test("bad frames");

      // 4 random back-pressure, at most 200 bytes so nothing overflows
      ready_mode <= READY_RANDOM;
      ovf_base = ovf_cnt;
      for (int i = 0; i < BP_FRAMES; i++) begin
         send_frame(rand_range(4, 20), 1'b0, rand_range(0, 3));
      end
      drive_idle();
      wait_drain();
      check_all_delivered();
      check_value("rx_fifo_overflow pulses", ovf_cnt - ovf_base, 0);
      finish_test("back-pressure");

      // 5 client stalled while more than the depth is sent
      ready_mode <= READY_LOW;
      lossy      <= 1'b1;
      drive_idle();
      ovf_base    = ovf_cnt;
      pause_base  = pause_cnt;
      missing_cnt = 0;
      check_value("pause_val next expected", pause_next, PAUSE_QUANTA_MAX);
      send_frame(BIG_LEN, 1'b0, 2);
      for (int i = 0; i < OVF_FRAMES; i++) begin
         send_frame(rand_range(40, MAX_LEN), 1'b0, rand_range(1, 3));
      end
      drive_idle();
      repeat (8) @(posedge rx_mac_aclk);
      ready_mode <= READY_HIGH;
      wait_drain();
      // frames still queued were lost at the tail
      missing_cnt += exp_len.size();
      exp_start.delete();
      exp_len.delete();
      assert (ovf_cnt > ovf_base) else begin
         $display("Error: no overflow pulse although the buffer was overrun");
         err_cnt++;
      end
      // the oversized frame is one of the pulses
      check_value("rx_fifo_overflow pulses", ovf_cnt - ovf_base, missing_cnt + 1);
      lossy <= 1'b0;
      finish_test("overflow");

      // 6 pause on then off during the overrun
      assert (pause_cnt - pause_base >= 2) else begin
         $display("Error: only %0d pause requests while the buffer filled and drained",
                  pause_cnt - pause_base);
         err_cnt++;
      end
      check_value("pause_val next expected", pause_next, PAUSE_QUANTA_MAX);
      finish_test("pause");

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_bad, total_errors());
      if (total_errors() == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile and run the receive fifo testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
      --top-module tb_rx_mac_fifo -f tb.f -o tb_rx_mac_fifo; then
   echo "verilator compile failed"
   exit 1
fi

# keep running after an assertion so the testbench can report it
./obj_dir/tb_rx_mac_fifo +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
   echo "simulation FAILED"
   exit 1
fi

echo "simulation PASSED"
exit 0

// ==== src/rx_client_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_client_reader import rx_mac_pkg::*; (
   input  logic  rx_mac_aclk,
   input  logic  rx_mac_resetn,
   // buffer read port
   input  logic  rd_avail,
   input  byte_t rd_byte,
   input  logic  rd_last,
   output logic  rd_en,
   // client stream
   output byte_t rx_axis_fifo_tdata,
   output logic  rx_axis_fifo_tvalid,
   output logic  rx_axis_fifo_tlast,
   input  logic  rx_axis_fifo_tready
);

   logic out_free;

   // ----------------------------------------------------------------------
   // refill control
   // ----------------------------------------------------------------------

   // register empty or being taken this cycle
   assign out_free = !rx_axis_fifo_tvalid || rx_axis_fifo_tready;

   // pop only committed bytes into a free slot
   assign rd_en = rd_avail && out_free;

   // ----------------------------------------------------------------------
   // output register
   // ----------------------------------------------------------------------

   // valid flag
   always_ff @(posedge rx_mac_aclk) begin
      if (!rx_mac_resetn) begin
         rx_axis_fifo_tvalid <= 1'b0;
      end else if (rd_en) begin
         rx_axis_fifo_tvalid <= 1'b1;
      end else if (rx_axis_fifo_tready) begin
         // consumed, nothing to follow yet
         rx_axis_fifo_tvalid <= 1'b0;
      end
   end

   // payload, held steady under back-pressure
   always_ff @(posedge rx_mac_aclk) begin
      if (rd_en) begin
         rx_axis_fifo_tdata <= rd_byte;
         rx_axis_fifo_tlast <= rd_last;
      end
   end

endmodule

`default_nettype wire

// ==== src/rx_frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_frame_buffer import rx_mac_pkg::*; #(
   parameter int FIFO_DEPTH = 256
) (
   input  logic         rx_mac_aclk,
   input  logic         rx_mac_resetn,
   // writer side
   input  logic         wr_en,
   input  byte_t        wr_byte,
   input  logic         wr_last,
   input  logic         commit,
   input  logic         rewind,
   output logic         full,
   // reader side
   input  logic         rd_en,
   output logic         rd_avail,
   output byte_t        rd_byte,
   output logic         rd_last,
   // occupancy for flow control
   output fifo_status_t fifo_status
);

   localparam int ADDR_W = $clog2(FIFO_DEPTH);

   // each entry is the last flag on top of the data byte
   logic [8:0]      mem [FIFO_DEPTH];

   // one extra bit tells full from empty
   logic [ADDR_W:0] wr_ptr;
   logic [ADDR_W:0] cmt_ptr;
   logic [ADDR_W:0] rd_ptr;
   logic [ADDR_W:0] used;

   // ----------------------------------------------------------------------
   // storage
   // ----------------------------------------------------------------------
   always_ff @(posedge rx_mac_aclk) begin
      if (wr_en) begin
         mem[wr_ptr[ADDR_W-1:0]] <= {wr_last, wr_byte};
      end
   end

   // reader only sees bytes behind the commit pointer
   assign rd_avail = (rd_ptr != cmt_ptr);
   assign rd_byte  = mem[rd_ptr[ADDR_W-1:0]][7:0];
   assign rd_last  = mem[rd_ptr[ADDR_W-1:0]][8];

   // ----------------------------------------------------------------------
   // pointers
   // ----------------------------------------------------------------------
   always_ff @(posedge rx_mac_aclk) begin
      if (!rx_mac_resetn) begin
         wr_ptr  <= '0;
         cmt_ptr <= '0;
         rd_ptr  <= '0;
      end else begin
         // rewind throws away the open frame
         if (rewind) begin
            wr_ptr <= cmt_ptr;
         end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         // commit comes with the last byte's write
         if (commit) begin
            cmt_ptr <= wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // open frame counts against space too
   assign used = wr_ptr - rd_ptr;
   // used never exceeds depth, so the top bit alone means full
   assign full = used[ADDR_W];

   // ----------------------------------------------------------------------
   // occupancy in sixteenths, saturated at 15 when full
   // ----------------------------------------------------------------------
   always_ff @(posedge rx_mac_aclk) begin
      if (!rx_mac_resetn) begin
         fifo_status <= '0;
      end else if (used[ADDR_W]) begin
         fifo_status <= 4'hf;
      end else begin
         fifo_status <= used[ADDR_W-1 -: 4];
      end
   end

endmodule

`default_nettype wire

// ==== src/rx_frame_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_frame_writer import rx_mac_pkg::*; (
   input  logic        rx_mac_aclk,
   input  logic        rx_mac_resetn,
   // mac side, no ready
   input  byte_t       rx_axis_mac_tdata,
   input  logic        rx_axis_mac_tvalid,
   input  logic        rx_axis_mac_tlast,
   input  logic        rx_axis_mac_tuser,
   // buffer write port
   input  logic        full,
   output logic        wr_en,
   output byte_t       wr_byte,
   output logic        wr_last,
   output logic        commit,
   output logic        rewind,
   // status
   output logic [31:0] rx_error_count,
   output logic        rx_fifo_overflow
);

   writer_state_t state;
   writer_state_t state_nxt;
   logic          bad_last;
   logic          ovf_last;

   // data goes straight to the buffer, control decides if it sticks
   assign wr_byte = rx_axis_mac_tdata;

   // ----------------------------------------------------------------------
   // per-byte write and drop decisions
   // ----------------------------------------------------------------------
   always_comb begin
      state_nxt = state;
      wr_en     = 1'b0;
      wr_last   = 1'b0;
      commit    = 1'b0;
      rewind    = 1'b0;
      bad_last  = 1'b0;
      ovf_last  = 1'b0;
      if (rx_axis_mac_tvalid) begin
         case (state)
            WR_IDLE, WR_FRAME: begin
               if (rx_axis_mac_tlast && rx_axis_mac_tuser) begin
                  // bad frame, last byte itself is never stored
                  rewind    = 1'b1;
                  bad_last  = 1'b1;
                  state_nxt = WR_IDLE;
               end else if (full) begin
                  // no room, whole frame goes
                  if (rx_axis_mac_tlast) begin
                     rewind    = 1'b1;
                     ovf_last  = 1'b1;
                     state_nxt = WR_IDLE;
                  end else begin
                     state_nxt = WR_DROP;
                  end
               end else begin
                  wr_en     = 1'b1;
                  wr_last   = rx_axis_mac_tlast;
                  // good last byte publishes the frame
                  commit    = rx_axis_mac_tlast;
                  state_nxt = rx_axis_mac_tlast ? WR_IDLE : WR_FRAME;
               end
            end
            WR_DROP: begin
               // swallow the rest, tuser here counts as overflow only
               if (rx_axis_mac_tlast) begin
                  rewind    = 1'b1;
                  ovf_last  = 1'b1;
                  state_nxt = WR_IDLE;
               end
            end
            default: state_nxt = WR_IDLE;
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // state, error counter and overflow pulse
   // ----------------------------------------------------------------------
   always_ff @(posedge rx_mac_aclk) begin
      if (!rx_mac_resetn) begin
         state            <= WR_IDLE;
         rx_error_count   <= 32'd0;
         rx_fifo_overflow <= 1'b0;
      end else begin
         state            <= state_nxt;
         rx_fifo_overflow <= ovf_last;
         if (bad_last) begin
            rx_error_count <= rx_error_count + 32'd1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== src/rx_mac_fifo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_mac_fifo_top import rx_mac_pkg::*; #(
   parameter int FIFO_DEPTH = 256
) (
   input  logic        rx_mac_aclk,
   input  logic        rx_mac_resetn,
   // from the mac
   input  byte_t       rx_axis_mac_tdata,
   input  logic        rx_axis_mac_tvalid,
   input  logic        rx_axis_mac_tlast,
   input  logic        rx_axis_mac_tuser,
   // to the client
   output byte_t       rx_axis_fifo_tdata,
   output logic        rx_axis_fifo_tvalid,
   output logic        rx_axis_fifo_tlast,
   input  logic        rx_axis_fifo_tready,
   // flow control toward the mac transmitter
   output logic        pause_req,
   output logic [15:0] pause_val,
   // status
   output logic [31:0] rx_error_count,
   output logic        rx_fifo_overflow
);

   // ----------------------------------------------------------------------
   // internal wiring
   // ----------------------------------------------------------------------

   // writer to buffer
   logic         wr_en;
   byte_t        wr_byte;
   logic         wr_last;
   logic         commit;
   logic         rewind;
   logic         full;

   // buffer to reader
   logic         rd_en;
   logic         rd_avail;
   byte_t        rd_byte;
   logic         rd_last;

   // buffer to pause controller
   fifo_status_t fifo_status;

   // ----------------------------------------------------------------------
   // frame writer, drops bad and oversized frames
   // ----------------------------------------------------------------------
   rx_frame_writer u_writer (
      .rx_mac_aclk        (rx_mac_aclk),
      .rx_mac_resetn      (rx_mac_resetn),
      .rx_axis_mac_tdata  (rx_axis_mac_tdata),
      .rx_axis_mac_tvalid (rx_axis_mac_tvalid),
      .rx_axis_mac_tlast  (rx_axis_mac_tlast),
      .rx_axis_mac_tuser  (rx_axis_mac_tuser),
      .full               (full),
      .wr_en              (wr_en),
      .wr_byte            (wr_byte),
      .wr_last            (wr_last),
      .commit             (commit),
      .rewind             (rewind),
      .rx_error_count     (rx_error_count),
      .rx_fifo_overflow   (rx_fifo_overflow)
   );

   // frame store
   rx_frame_buffer #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_buffer (
      .rx_mac_aclk   (rx_mac_aclk),
      .rx_mac_resetn (rx_mac_resetn),
      .wr_en         (wr_en),
      .wr_byte       (wr_byte),
      .wr_last       (wr_last),
      .commit        (commit),
      .rewind        (rewind),
      .full          (full),
      .rd_en         (rd_en),
      .rd_avail      (rd_avail),
      .rd_byte       (rd_byte),
      .rd_last       (rd_last),
      .fifo_status   (fifo_status)
   );

   // client stream with back-pressure
   rx_client_reader u_reader (
      .rx_mac_aclk         (rx_mac_aclk),
      .rx_mac_resetn       (rx_mac_resetn),
      .rd_avail            (rd_avail),
      .rd_byte             (rd_byte),
      .rd_last             (rd_last),
      .rd_en               (rd_en),
      .rx_axis_fifo_tdata  (rx_axis_fifo_tdata),
      .rx_axis_fifo_tvalid (rx_axis_fifo_tvalid),
      .rx_axis_fifo_tlast  (rx_axis_fifo_tlast),
      .rx_axis_fifo_tready (rx_axis_fifo_tready)
   );

   // pause requests from buffer fill
   rx_pause_ctrl u_pause (
      .rx_mac_aclk   (rx_mac_aclk),
      .rx_mac_resetn (rx_mac_resetn),
      .fifo_status   (fifo_status),
      .pause_req     (pause_req),
      .pause_val     (pause_val)
   );

endmodule

`default_nettype wire

// ==== src/rx_mac_pkg.sv ====
`default_nettype none

package rx_mac_pkg;

   // ----------------------------------------------------------------------
   // stream and status types
   // ----------------------------------------------------------------------

   // one byte of the mac receive stream
   typedef logic [7:0] byte_t;

   // buffer occupancy in sixteenths of the depth
   typedef logic [3:0] fifo_status_t;

   // ----------------------------------------------------------------------
   // flow control thresholds and pause values
   // ----------------------------------------------------------------------

   // pause asked above this level
   localparam fifo_status_t FIFO_HIGH = 4'd8;
   // pause released at or below this level
   localparam fifo_status_t FIFO_LOW  = 4'd4;

   // longest pause the mac can request
   localparam logic [15:0] PAUSE_QUANTA_MAX  = 16'hffff;
   // zero quanta cancels a running pause at the link partner
   localparam logic [15:0] PAUSE_QUANTA_ZERO = 16'h0000;

   // ----------------------------------------------------------------------
   // fsm encodings
   // ----------------------------------------------------------------------

   // per-frame state of the writer
   typedef enum logic [1:0] {
      WR_IDLE  = 2'd0,
      WR_FRAME = 2'd1,
      WR_DROP  = 2'd2
   } writer_state_t;

   // pause fsm, on means a 16'hffff request is outstanding
   typedef enum logic {
      PAUSE_OFF = 1'b0,
      PAUSE_ON  = 1'b1
   } pause_state_t;

endpackage

`default_nettype wire

// ==== src/rx_pause_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_pause_ctrl import rx_mac_pkg::*; (
   input  logic         rx_mac_aclk,
   input  logic         rx_mac_resetn,
   input  fifo_status_t fifo_status,
   output logic         pause_req,
   output logic [15:0]  pause_val
);

   logic         sample_tick;
   fifo_status_t status_slow;
   pause_state_t state;
   logic         go_on;
   logic         go_off;

   // ----------------------------------------------------------------------
   // status sampling, every second cycle
   // ----------------------------------------------------------------------
   always_ff @(posedge rx_mac_aclk) begin
      if (!rx_mac_resetn) begin
         sample_tick <= 1'b0;
         status_slow <= '0;
      end else begin
         sample_tick <= !sample_tick;
         if (sample_tick) begin
            status_slow <= fifo_status;
         end
      end
   end

   // threshold crossings, hysteresis between low and high
   assign go_on  = (state == PAUSE_OFF) && (status_slow > FIFO_HIGH);
   assign go_off = (state == PAUSE_ON) && (status_slow <= FIFO_LOW);

   // ----------------------------------------------------------------------
   // pause fsm
   // ----------------------------------------------------------------------
   always_ff @(posedge rx_mac_aclk) begin
      if (!rx_mac_resetn) begin
         state     <= PAUSE_OFF;
         pause_req <= 1'b0;
      end else begin
         // single cycle request per transition
         pause_req <= go_on || go_off;
         if (go_on) begin
            state <= PAUSE_ON;
         end else if (go_off) begin
            state <= PAUSE_OFF;
         end
      end
   end

   // value only matters alongside pause_req
   always_ff @(posedge rx_mac_aclk) begin
      if (go_on) begin
         pause_val <= PAUSE_QUANTA_MAX;
      end else if (go_off) begin
         pause_val <= PAUSE_QUANTA_ZERO;
      end
   end

endmodule

`default_nettype wire

// ==== tb.f ====
src/rx_mac_pkg.sv
src/rx_frame_writer.sv
src/rx_frame_buffer.sv
src/rx_client_reader.sv
src/rx_pause_ctrl.sv
src/rx_mac_fifo_top.sv
dv/tb_clk_gen.sv
dv/rx_mac_fifo_asserts.sv
dv/tb_rx_mac_fifo.sv
